//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_evr_timing
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "test passed" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/evr_decode.sv
`timescale 1ns/1ns

module evr_decode
    import evr_pkg::*;
(
    input  logic        i_arst_n,
    input  logic        evr_clk,
    input  logic [15:0] i_rxd,
    input  logic [1:0]  i_rxk,
    output evr_dec_t    o_dec
);

    evr_word_u              rx_word;
    logic                   is_frame;
    logic [7:0]             evcode;
    logic [7:0]             dbus;
    logic                   ev_valid;
    logic                   is_shift;
    logic                   shift_bit;
    logic                   is_pps;
    logic                   is_hb;

    logic [31:0]            secs_sr;
    logic [SHIFT_CNT_W-1:0] shift_cnt;
    logic [31:0]            secs_q;
    logic [31:0]            tcks_q;
    logic                   ts_valid_q;

    // ------------------------------
    // word decode
    // ------------------------------

    assign rx_word  = i_rxd;
    // K on the low byte selects the frame view
    assign is_frame = i_rxk[0];

    // the high byte is the dbus in either view
    assign dbus   = rx_word.frame.data;
    assign evcode = is_frame ? 8'h00 : rx_word.ev.evcode;

    // code 0x00 is the null event
    assign ev_valid  = !is_frame && (evcode != 8'h00);
    assign is_shift  = ev_valid && ((evcode == EVCODE_SHIFT0) || (evcode == EVCODE_SHIFT1));
    assign shift_bit = (evcode == EVCODE_SHIFT1);
    assign is_pps    = ev_valid && (evcode == EVCODE_PPS);
    assign is_hb     = ev_valid && (evcode == EVCODE_HEARTBEAT);

    // ------------------------------
    // seconds assembly and ticks
    // ------------------------------

    always_ff @(posedge evr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            secs_sr    <= '0;
            shift_cnt  <= '0;
            secs_q     <= '0;
            tcks_q     <= '0;
            ts_valid_q <= 1'b0;
        end else begin
            if (is_shift) begin
                secs_sr <= {secs_sr[30:0], shift_bit};
                // saturate so that an overlong word never looks complete
                if (shift_cnt != SHIFT_CNT_SAT) begin
                    shift_cnt <= shift_cnt + 1'b1;
                end
            end
            if (is_pps) begin
                secs_q     <= secs_sr;
                tcks_q     <= '0;
                // valid only when exactly one full word preceded this pps
                ts_valid_q <= (shift_cnt == SHIFT_CNT_W'(SECS_BITS));
                shift_cnt  <= '0;
            end else begin
                tcks_q <= tcks_q + 32'd1;
            end
        end
    end

    // ------------------------------
    // output register
    // ------------------------------

    // the timestamp is the one live when the word arrived, so the
    // reloaded seconds and zero ticks follow the pps strobe by a cycle
    always_ff @(posedge evr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_dec <= '0;
        end else begin
            o_dec.ev_valid <= ev_valid;
            o_dec.evcode   <= evcode;
            o_dec.dbus     <= dbus;
            o_dec.pps      <= is_pps;
            o_dec.hb       <= is_hb;
            o_dec.ts_valid <= ts_valid_q;
            o_dec.ts.secs  <= secs_q;
            o_dec.ts.tcks  <= tcks_q;
        end
    end

endmodule

//--- hdl/evr_event_exec.sv
`timescale 1ns/1ns

module evr_event_exec
    import evr_pkg::*;
(
    input  logic       i_arst_n,
    input  logic       evr_clk,
    input  evr_dec_t   i_dec,
    input  logic [7:0] i_evcode,
    output evr_exec_t  o_exe
);

    logic        ev_match;
    logic        count_en;

    // ------------------------------
    // event selection
    // ------------------------------

    // a null code never decodes as valid, so i_evcode of zero selects nothing
    assign ev_match = i_dec.ev_valid && (i_dec.evcode == i_evcode);

    // events before a full seconds word are only partly decoded,
    // they still strobe but are not counted
    assign count_en = ev_match && i_dec.ts_valid;

    // ------------------------------
    // stage register and event counter
    // ------------------------------

    // markers, dbus and timestamp move in step with the strobe
    // counter already holds the new value when the strobe shows
    always_ff @(posedge evr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_exe.event_stb <= 1'b0;
            o_exe.pps       <= 1'b0;
            o_exe.hb        <= 1'b0;
            o_exe.ts_valid  <= 1'b0;
            o_exe.ts        <= '0;
            o_exe.event_cnt <= '0;
            o_exe.dbus      <= '0;
        end else begin
            o_exe.event_stb <= ev_match;
            o_exe.pps       <= i_dec.pps;
            o_exe.hb        <= i_dec.hb;
            o_exe.ts_valid  <= i_dec.ts_valid;
            o_exe.ts        <= i_dec.ts;
            o_exe.dbus      <= i_dec.dbus;
            if (count_en) begin
                o_exe.event_cnt <= o_exe.event_cnt + 32'd1;
            end
        end
    end

endmodule

//--- hdl/evr_pkg.sv
package evr_pkg;

    // ------------------------------
    // event codes and link characters
    // ------------------------------

    // seconds word is sent MSB first, one shift code per bit
    localparam logic [7:0] EVCODE_SHIFT0    = 8'h70;
    localparam logic [7:0] EVCODE_SHIFT1    = 8'h71;
    // loads the assembled seconds and restarts the ticks
    localparam logic [7:0] EVCODE_PPS       = 8'h7D;
    localparam logic [7:0] EVCODE_HEARTBEAT = 8'h7A;
    // comma sent in the low byte of idle frames
    localparam logic [7:0] K28_5            = 8'hBC;

    // shift codes in one complete seconds word
    localparam int SECS_BITS   = 32;
    // shift counter width and its saturation value, one past a full word
    localparam int SHIFT_CNT_W = 6;
    localparam logic [SHIFT_CNT_W-1:0] SHIFT_CNT_SAT = SHIFT_CNT_W'(SECS_BITS + 1);

    // ------------------------------
    // link word views
    // ------------------------------

    // K flag on the low byte: comma in the low byte, data in the high byte
    typedef struct packed {
        logic [7:0] data;
        logic [7:0] comma;
    } evr_frame_t;

    // no K flag: distributed bus in the high byte, event code in the low byte
    typedef struct packed {
        logic [7:0] dbus;
        logic [7:0] evcode;
    } evr_event_t;

    typedef union packed {
        evr_frame_t frame;
        evr_event_t ev;
    } evr_word_u;

    // ------------------------------
    // timestamp and stage outputs
    // ------------------------------

    typedef struct packed {
        logic [31:0] secs;
        logic [31:0] tcks;
    } evr_ts_t;

    // decode stage, one cycle after the link word
    typedef struct packed {
        logic       ev_valid;
        logic [7:0] evcode;
        logic [7:0] dbus;
        logic       pps;
        logic       hb;
        logic       ts_valid;
        evr_ts_t    ts;
    } evr_dec_t;

    // execute stage, one cycle after decode
    // event_stb is the strobe for the user-selected code
    typedef struct packed {
        logic        event_stb;
        logic        pps;
        logic        hb;
        logic        ts_valid;
        evr_ts_t     ts;
        logic [31:0] event_cnt;
        logic [7:0]  dbus;
    } evr_exec_t;

endpackage

//--- hdl/evr_timing_top.sv
`timescale 1ns/1ns

module evr_timing_top
    import evr_pkg::*;
(
    input  logic        i_arst_n,
    input  logic        evr_clk,
    input  logic [15:0] i_rxd,
    input  logic [1:0]  i_rxk,
    input  logic [7:0]  i_evcode,
    input  logic [6:0]  i_oc_delay,
    output logic        o_event,
    output logic        o_pps,
    output logic        o_hb,
    output logic        o_ts_valid,
    output logic        o_oc_trig,
    output evr_ts_t     o_ts,
    output evr_ts_t     o_oc_ts,
    output logic [31:0] o_event_cnt,
    output logic [7:0]  o_dbus
);

    evr_dec_t  dec;
    evr_exec_t exe;

    // link word to decoded event and live timestamp
    evr_decode u_decode (
        .i_arst_n (i_arst_n),
        .evr_clk  (evr_clk),
        .i_rxd    (i_rxd),
        .i_rxk    (i_rxk),
        .o_dec    (dec)
    );

    // user event strobe and gated count
    evr_event_exec u_exec (
        .i_arst_n (i_arst_n),
        .evr_clk  (evr_clk),
        .i_dec    (dec),
        .i_evcode (i_evcode),
        .o_exe    (exe)
    );

    // delayed trigger and output registers
    evr_trig_result u_result (
        .i_arst_n    (i_arst_n),
        .evr_clk     (evr_clk),
        .i_exe       (exe),
        .i_oc_delay  (i_oc_delay),
        .o_event     (o_event),
        .o_pps       (o_pps),
        .o_hb        (o_hb),
        .o_ts_valid  (o_ts_valid),
        .o_oc_trig   (o_oc_trig),
        .o_ts        (o_ts),
        .o_oc_ts     (o_oc_ts),
        .o_event_cnt (o_event_cnt),
        .o_dbus      (o_dbus)
    );

endmodule

//--- hdl/evr_trig_result.sv
`timescale 1ns/1ns

module evr_trig_result
    import evr_pkg::*;
(
    input  logic        i_arst_n,
    input  logic        evr_clk,
    input  evr_exec_t   i_exe,
    input  logic [6:0]  i_oc_delay,
    output logic        o_event,
    output logic        o_pps,
    output logic        o_hb,
    output logic        o_ts_valid,
    output logic        o_oc_trig,
    output evr_ts_t     o_ts,
    output evr_ts_t     o_oc_ts,
    output logic [31:0] o_event_cnt,
    output logic [7:0]  o_dbus
);

    logic [6:0] oc_cnt;
    logic       oc_inprog;
    logic       oc_fire;

    // ------------------------------
    // trigger delay
    // ------------------------------

    // count runs 1, 2, ... and wraps through 0, so a delay of 0 gives 128
    assign oc_fire = oc_inprog && (oc_cnt == i_oc_delay);

    always_ff @(posedge evr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            oc_cnt    <= '0;
            oc_inprog <= 1'b0;
        end else if (i_exe.event_stb) begin
            // a new event restarts a delay already running
            oc_cnt    <= 7'd1;
            oc_inprog <= 1'b1;
        end else if (oc_inprog) begin
            oc_cnt <= oc_cnt + 7'd1;
            if (oc_fire) begin
                oc_inprog <= 1'b0;
            end
        end
    end

    // ------------------------------
    // output stage
    // ------------------------------

    // captured timestamp is taken at the same edge as o_ts
    always_ff @(posedge evr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_event     <= 1'b0;
            o_pps       <= 1'b0;
            o_hb        <= 1'b0;
            o_ts_valid  <= 1'b0;
            o_oc_trig   <= 1'b0;
            o_ts        <= '0;
            o_oc_ts     <= '0;
            o_event_cnt <= '0;
            o_dbus      <= '0;
        end else begin
            o_event     <= i_exe.event_stb;
            o_pps       <= i_exe.pps;
            o_hb        <= i_exe.hb;
            o_ts_valid  <= i_exe.ts_valid;
            o_oc_trig   <= oc_fire;
            o_ts        <= i_exe.ts;
            o_event_cnt <= i_exe.event_cnt;
            o_dbus      <= i_exe.dbus;
            if (oc_fire) begin
                o_oc_ts <= i_exe.ts;
            end
        end
    end

endmodule

//--- sim/evr_clk_gen.sv
`timescale 1ns/1ns

module evr_clk_gen (
    output logic o_clk
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

//--- sim/evr_timing_checker.sv
`timescale 1ns/1ns

module evr_timing_checker
    import evr_pkg::*;
(
    input logic        evr_clk,
    input logic        i_arst_n,
    input logic        o_event,
    input logic        o_pps,
    input logic        o_oc_trig,
    input evr_ts_t     o_ts,
    input evr_ts_t     o_oc_ts,
    input logic [31:0] o_event_cnt
);

    // number of failed assertions
    int assert_fails = 0;

    // captured timestamp matches the live one when the trigger fires
    a_trig_ts: assert property (@(posedge evr_clk) disable iff (!i_arst_n)
        o_oc_trig |-> (o_oc_ts == o_ts))
        else begin
            $error("o_oc_ts differs from o_ts on trigger");
            assert_fails++;
        end

    // the counter only moves together with the event strobe
    a_cnt_event: assert property (@(posedge evr_clk) disable iff (!i_arst_n)
        $changed(o_event_cnt) |-> o_event)
        else begin
            $error("o_event_cnt changed without o_event");
            assert_fails++;
        end

    // ticks restart right after the pps marker
    a_pps_tcks: assert property (@(posedge evr_clk) disable iff (!i_arst_n)
        o_pps |=> (o_ts.tcks == 32'd0))
        else begin
            $error("o_ts.tcks not zero after o_pps");
            assert_fails++;
        end

endmodule

//--- sim/tb_evr_timing.sv
`timescale 1ns/1ns

module tb_evr_timing
    import evr_pkg::*;
();

    typedef struct packed {
        logic        event_hit;
        logic        pps;
        logic        hb;
        logic        ts_valid;
        logic        oc_trig;
        evr_ts_t     ts;
        evr_ts_t     oc_ts;
        logic [31:0] event_cnt;
        logic [7:0]  dbus;
    } exp_t;

    logic        evr_clk;
    logic        i_arst_n;
    logic [15:0] i_rxd;
    logic [1:0]  i_rxk;
    logic [7:0]  i_evcode;
    logic [6:0]  i_oc_delay;
    logic        o_event;
    logic        o_pps;
    logic        o_hb;
    logic        o_ts_valid;
    logic        o_oc_trig;
    evr_ts_t     o_ts;
    evr_ts_t     o_oc_ts;
    logic [31:0] o_event_cnt;
    logic [7:0]  o_dbus;
    logic [7:0]  cfg_evcode;
    logic [6:0]  cfg_delay;
    exp_t        exp_q[$];
    logic [15:0] lfsr = 16'd54636;
    int          errors = 0;
    int          direct_errs = 0;
    int          ntests = 0;
    int          ev_seen = 0;
    int          trig_seen = 0;
    // reference model state
    logic [31:0] m_sr, m_secs, m_tcks, m_cnt;
    logic        m_tsv, m_inprog;
    int          m_shcnt, m_oc_cnt;
    evr_ts_t     m_oc_ts;

    evr_clk_gen u_clk (.o_clk(evr_clk));

    evr_timing_top dut (.*);

    bind evr_timing_top evr_timing_checker u_checker (.*);

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // expected outputs three cycles after the word
    function automatic exp_t model_step(input logic [15:0] rxd, input logic [1:0] rxk);
        exp_t       e;
        logic [7:0] code;
        logic       valid;
        int         eff;
        e       = '0;
        code    = rxk[0] ? 8'h00 : rxd[7:0];
        valid   = (code != 8'h00);
        e.dbus  = rxd[15:8];
        e.pps   = valid && (code == EVCODE_PPS);
        e.hb    = valid && (code == EVCODE_HEARTBEAT);
        e.ts    = {m_secs, m_tcks};
        e.ts_valid  = m_tsv;
        e.event_hit = valid && (code == cfg_evcode);
        if (e.event_hit && m_tsv) begin
            m_cnt = m_cnt + 1;
        end
        e.event_cnt = m_cnt;
        // delay of 0 means 128
        eff       = (cfg_delay == 0) ? 128 : int'(cfg_delay);
        e.oc_trig = m_inprog && (m_oc_cnt == eff);
        if (e.oc_trig) begin
            m_oc_ts = e.ts;
        end
        e.oc_ts = m_oc_ts;
        if (e.event_hit) begin
            m_oc_cnt = 1;
            m_inprog = 1'b1;
        end else if (m_inprog) begin
            m_oc_cnt = m_oc_cnt + 1;
            if (e.oc_trig) begin
                m_inprog = 1'b0;
            end
        end
        if (valid && (code == EVCODE_SHIFT0 || code == EVCODE_SHIFT1)) begin
            m_sr = {m_sr[30:0], code == EVCODE_SHIFT1};
            if (m_shcnt < SECS_BITS + 1) begin
                m_shcnt = m_shcnt + 1;
            end
        end
        if (e.pps) begin
            m_secs  = m_sr;
            m_tcks  = '0;
            m_tsv   = (m_shcnt == SECS_BITS);
            m_shcnt = 0;
        end else begin
            m_tcks = m_tcks + 1;
        end
        return e;
    endfunction

    // mismatches from the compare process, direct checks and bound assertions
    function automatic int error_count();
        return errors + direct_errs + dut.u_checker.assert_fails;
    endfunction

    // ------------------------------
    // stimulus helpers
    // ------------------------------

    task automatic drive_word(input logic [15:0] rxd, input logic [1:0] rxk);
        @(posedge evr_clk);
        i_arst_n <= 1'b1;
        i_rxd    <= rxd;
        i_rxk    <= rxk;
        exp_q.push_back(model_step(rxd, rxk));
    endtask

    task automatic idle(input int n);
        repeat (n) drive_word({8'(rand_bits(8)), K28_5}, 2'b01);
    endtask

    task automatic send_secs(input logic [31:0] secs, input int nbits);
        for (int i = nbits - 1; i >= 0; i--) begin
            drive_word({8'h00, secs[i] ? EVCODE_SHIFT1 : EVCODE_SHIFT0}, 2'b00);
        end
        drive_word({8'h00, EVCODE_PPS}, 2'b00);
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("test failed");
        $finish;
    endtask

    function automatic logic sig_now(input int sel);
        case (sel)
            0: return o_ts_valid;
            1: return !o_ts_valid;
            2: return o_hb;
            3: return o_pps;
            default: return o_oc_trig;
        endcase
    endfunction

    // idles until the selected output is seen at the falling edge
    task automatic wait_signal(input int sel, input int limit, output int n);
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            idle(1);
            @(negedge evr_clk);
            n++;
            seen = sig_now(sel);
        end
        if (!seen) begin
            timeout_abort($sformatf("output select %0d", sel));
        end
    endtask

    task automatic set_config(input logic [7:0] code, input logic [6:0] delay);
        int n;
        n = 0;
        while (m_inprog && n < 300) begin
            idle(1);
            n++;
        end
        if (m_inprog) begin
            timeout_abort("trigger delay to finish");
        end
        idle(4);
        i_evcode   <= code;
        i_oc_delay <= delay;
        cfg_evcode = code;
        cfg_delay  = delay;
    endtask

    task automatic expect_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            direct_errs++;
        end
    endtask

    task automatic test_done(input string name, input int e0);
        idle(4);
        ntests++;
        $display("%s finished with %0d errors", name, error_count() - e0);
    endtask

    // ------------------------------
    // compare process
    // ------------------------------

    always @(negedge evr_clk) begin
        exp_t e;
        if (i_arst_n && o_event) ev_seen++;
        if (i_arst_n && o_oc_trig) trig_seen++;
        if (exp_q.size() == 4) begin
            e = exp_q.pop_front();
            if (o_event !== e.event_hit) begin
                $display("error o_event got %h expected %h", o_event, e.event_hit);
                errors++;
            end
            if ({o_pps, o_hb, o_ts_valid} !== {e.pps, e.hb, e.ts_valid}) begin
                $display("error o_pps/o_hb/o_ts_valid got %h expected %h",
                         {o_pps, o_hb, o_ts_valid}, {e.pps, e.hb, e.ts_valid});
                errors++;
            end
            if (o_oc_trig !== e.oc_trig) begin
                $display("error o_oc_trig got %h expected %h", o_oc_trig, e.oc_trig);
                errors++;
            end
            if (o_ts !== e.ts) begin
                $display("error o_ts got %h expected %h", o_ts, e.ts);
                errors++;
            end
            if (o_oc_ts !== e.oc_ts) begin
                $display("error o_oc_ts got %h expected %h", o_oc_ts, e.oc_ts);
                errors++;
            end
            if (o_event_cnt !== e.event_cnt) begin
                $display("error o_event_cnt got %h expected %h", o_event_cnt, e.event_cnt);
                errors++;
            end
            if (o_dbus !== e.dbus) begin
                $display("error o_dbus got %h expected %h", o_dbus, e.dbus);
                errors++;
            end
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin
        int          e0, n, ev0, hits, eff;
        logic [31:0] secs, c0;
        logic [7:0]  user, code;
        logic [6:0]  dly;
        i_arst_n = 1'b0;
        i_rxd = {8'h00, K28_5};
        i_rxk = 2'b01;
        i_evcode = 8'h00;
        i_oc_delay = 7'd0;
        cfg_evcode = 8'h00;
        cfg_delay = 7'd0;
        {m_sr, m_secs, m_tcks, m_cnt, m_tsv, m_inprog, m_shcnt, m_oc_cnt, m_oc_ts} = '0;
        repeat (4) @(posedge evr_clk);

        // timestamp acquisition
        e0 = 0;
        secs = rand_bits(32);
        send_secs(secs, 32);
        wait_signal(0, 10, n);
        expect_hex("o_ts.secs", o_ts.secs, secs);
        expect_hex("o_ts.tcks", o_ts.tcks, 0);
        idle(5);
        if (o_ts.tcks == 0) begin
            $display("o_ts.tcks did not count up after pps");
            direct_errs++;
        end
        test_done("timestamp acquisition", e0);

        // incomplete seconds word
        e0 = error_count();
        send_secs(rand_bits(20), 20);
        wait_signal(1, 10, n);
        set_config(8'h23, 7'd100);
        ev0 = ev_seen;
        c0  = o_event_cnt;
        repeat (5) begin
            drive_word({8'(rand_bits(8)), 8'h23}, 2'b00);
            idle(2);
        end
        idle(4);
        expect_hex("o_event pulses", ev_seen - ev0, 5);
        expect_hex("o_event_cnt", o_event_cnt, c0);
        test_done("incomplete seconds word", e0);

        // event selection and counting
        e0 = error_count();
        send_secs(rand_bits(32), 32);
        user = {1'b1, 7'(rand_bits(7))};
        set_config(user, 7'd50);
        ev0  = ev_seen;
        c0   = o_event_cnt;
        hits = 0;
        repeat (200) begin
            if (rand_bits(1) != 0) begin
                idle(1);
            end else begin
                code = (rand_bits(1) != 0) ? user : 8'(rand_bits(8));
                if (code == EVCODE_SHIFT0 || code == EVCODE_SHIFT1 || code == EVCODE_PPS) begin
                    code = code ^ 8'h80;
                end
                if (code == user) hits++;
                drive_word({8'(rand_bits(8)), code}, 2'b00);
            end
        end
        idle(4);
        expect_hex("o_event pulses", ev_seen - ev0, hits);
        expect_hex("o_event_cnt delta", o_event_cnt - c0, hits);
        test_done("event selection", e0);

        // markers
        e0 = error_count();
        drive_word({8'h00, EVCODE_HEARTBEAT}, 2'b00);
        @(negedge evr_clk);
        wait_signal(2, 10, n);
        expect_hex("o_hb latency", n, 3);
        drive_word({8'h00, EVCODE_PPS}, 2'b00);
        @(negedge evr_clk);
        wait_signal(3, 10, n);
        expect_hex("o_pps latency", n, 3);
        test_done("markers", e0);

        // trigger delay, the last round retriggers mid-delay
        e0 = error_count();
        for (int r = 0; r < 5; r++) begin
            dly = (r == 0) ? 7'd0 : 7'(rand_bits(7));
            if (r == 4) dly = dly | 7'd8;
            set_config(user, dly);
            eff = (dly == 0) ? 128 : int'(dly);
            ev0 = trig_seen;
            drive_word({8'h00, user}, 2'b00);
            if (r == 4) begin
                idle(3);
                drive_word({8'h00, user}, 2'b00);
            end
            @(negedge evr_clk);
            wait_signal(4, 300, n);
            expect_hex("o_oc_trig latency", n, 3 + eff);
            idle(1);
            expect_hex("o_oc_trig pulses", trig_seen - ev0, 1);
        end
        test_done("trigger delay", e0);

        idle(6);
        $display("%0d tests run, %0d errors", ntests, error_count());
        if (error_count() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
hdl/evr_pkg.sv
hdl/evr_decode.sv
hdl/evr_event_exec.sv
hdl/evr_trig_result.sv
hdl/evr_timing_top.sv
sim/evr_clk_gen.sv
sim/evr_timing_checker.sv
sim/tb_evr_timing.sv
